// File: hdl/free_list.sv
/* bitmap free list of physical tags for the ROB back end
   offers the two lowest free tags and takes back retired and flushed tags */
module free_list (
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic [rob_pkg::n_way-1:0]            dis_valid,
	input  logic [rob_pkg::n_way-1:0]            retire_valid,
	input  rob_pkg::tag_t [rob_pkg::n_way-1:0]   retire_tag,
	input  rob_pkg::tag_t [rob_pkg::n_way-1:0]   retire_told,
	input  logic                                 flush_valid,
	input  rob_pkg::tag_t [rob_pkg::n_rob-1:0]   flush_tags,
	output rob_pkg::tag_t [rob_pkg::n_way-1:0]   alloc_tag,
	output rob_pkg::way_cnt_t                    tag_space
);

	// one bit per physical tag, set when free
	logic [rob_pkg::n_preg-1:0] free_q;
	logic [rob_pkg::n_preg-1:0] free_next;
	logic [$clog2(rob_pkg::n_preg):0] free_cnt;

	// scan from the top so the lowest free tag ends in way 0
	// and the one above it in way 1
	always_comb begin
		alloc_tag = '0;
		for (int i = rob_pkg::n_preg - 1; i > 0; i--) begin
			if (free_q[i]) begin
				alloc_tag[1] = alloc_tag[0];
				alloc_tag[0] = rob_pkg::tag_t'(i);
			end
		end
	end

	always_comb begin
		free_cnt = '0;
		for (int i = 0; i < rob_pkg::n_preg; i++) begin
			free_cnt = free_cnt + free_q[i];
		end
	end

	assign tag_space = (free_cnt >= rob_pkg::n_way) ?
		rob_pkg::way_cnt_t'(rob_pkg::n_way) : rob_pkg::way_cnt_t'(free_cnt);

	always_comb begin
		free_next = free_q;

		// tags handed out this cycle
		// the ROB drops dispatch during a flush, so nothing is taken then
		if (!flush_valid) begin
			for (int w = 0; w < rob_pkg::n_way; w++) begin
				if (dis_valid[w] && alloc_tag[w] != rob_pkg::zero_tag) begin
					free_next[alloc_tag[w]] = 1'b0;
				end
			end
		end

		// retirement releases the previous mapping when there is one
		for (int w = 0; w < rob_pkg::n_way; w++) begin
			if (retire_valid[w]) begin
				if (retire_told[w] != rob_pkg::zero_tag) begin
					free_next[retire_told[w]] = 1'b1;
				end else if (retire_tag[w] != rob_pkg::zero_tag) begin
					free_next[retire_tag[w]] = 1'b1;
				end
			end
		end

		// every tag still held by the ROB comes back on a flush
		if (flush_valid) begin
			for (int k = 0; k < rob_pkg::n_rob; k++) begin
				if (flush_tags[k] != rob_pkg::zero_tag) begin
					free_next[flush_tags[k]] = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// initial map owns the low tags
			for (int i = 0; i < rob_pkg::n_preg; i++) begin
				free_q[i] <= (i >= rob_pkg::n_areg);
			end
		end else begin
			free_q <= free_next;
		end
	end

endmodule

// File: hdl/rob.sv
/* circular reorder buffer with one-hot head and tail tokens
   dispatch fills the slots after the tail, retire drains completed entries from the head */
module rob (
	input  logic                                            clock,
	input  logic                                            reset,
	input  logic [rob_pkg::n_way-1:0]                       dis_valid,
	input  rob_pkg::tag_t [rob_pkg::n_way-1:0]              dis_tag,
	input  rob_pkg::tag_t [rob_pkg::n_way-1:0]              dis_told,
	input  rob_pkg::inst_kind_e [rob_pkg::n_way-1:0]        dis_kind,
	input  rob_pkg::pc_t [rob_pkg::n_way-1:0]               dis_pc,
	input  rob_pkg::tag_t [rob_pkg::n_way-1:0]              complete_tag,
	input  logic                                            take_branch,
	input  rob_pkg::pc_t                                    br_result,
	output logic [rob_pkg::n_way-1:0]                       retire_valid,
	output rob_pkg::tag_t [rob_pkg::n_way-1:0]              retire_tag,
	output rob_pkg::tag_t [rob_pkg::n_way-1:0]              retire_told,
	output rob_pkg::pc_t [rob_pkg::n_way-1:0]               retire_pc,
	output logic [rob_pkg::n_way-1:0]                       retire_halt,
	output logic [rob_pkg::n_way-1:0]                       retire_illegal,
	output logic                                            branch_haz,
	output rob_pkg::pc_t                                    br_target_pc,
	output logic                                            retire_branch,
	output rob_pkg::pc_t                                    retire_branch_pc,
	output logic                                            flush_valid,
	output rob_pkg::tag_t [rob_pkg::n_rob-1:0]              flush_tags,
	output rob_pkg::way_cnt_t                               rob_space
);

	// ring control
	logic [rob_pkg::n_rob-1:0] head;
	logic [rob_pkg::n_rob-1:0] tail;
	logic [rob_pkg::n_rob-1:0] busy;
	logic [rob_pkg::n_rob-1:0] done;
	rob_pkg::rob_cnt_t         free_cnt;

	// entry payload
	rob_pkg::tag_t       tag_q [rob_pkg::n_rob];
	rob_pkg::tag_t       told_q [rob_pkg::n_rob];
	rob_pkg::inst_kind_e kind_q [rob_pkg::n_rob];
	rob_pkg::pc_t        pc_q [rob_pkg::n_rob];
	rob_pkg::pc_t        target_q [rob_pkg::n_rob];
	logic [rob_pkg::n_rob-1:0] taken_q;

	// head slots looked at by the retire scan
	logic [rob_pkg::n_way-1:0][rob_pkg::n_rob-1:0] head_at;
	logic [rob_pkg::n_way-1:0]                     s_busy;
	logic [rob_pkg::n_way-1:0]                     s_done;
	logic [rob_pkg::n_way-1:0]                     s_taken;
	rob_pkg::inst_kind_e [rob_pkg::n_way-1:0]      s_kind;
	rob_pkg::tag_t [rob_pkg::n_way-1:0]            s_tag;
	rob_pkg::tag_t [rob_pkg::n_way-1:0]            s_told;
	rob_pkg::pc_t [rob_pkg::n_way-1:0]             s_pc;
	rob_pkg::pc_t [rob_pkg::n_way-1:0]             s_target;
	logic                                          scan_stop;

	// dispatch and completion
	logic [rob_pkg::n_way-1:0] dis_go;
	logic [rob_pkg::n_rob-1:0] tail1;
	logic [rob_pkg::n_rob-1:0] tail2;
	logic [rob_pkg::n_rob-1:0] slot0;
	logic [rob_pkg::n_rob-1:0] slot1;
	logic [rob_pkg::n_rob-1:0] written;
	logic [rob_pkg::n_rob-1:0] hit;
	logic [rob_pkg::n_rob-1:0] halt_self;
	logic [rob_pkg::n_rob-1:0] retired;
	logic [rob_pkg::n_rob-1:0] head_next;
	logic [rob_pkg::n_rob-1:0] tail_next;
	rob_pkg::rob_cnt_t         n_ret;
	rob_pkg::rob_cnt_t         n_dis;

	// advance a token by one entry, wrapping at the top
	function automatic logic [rob_pkg::n_rob-1:0] step(input logic [rob_pkg::n_rob-1:0] tok);
		return {tok[rob_pkg::n_rob-2:0], tok[rob_pkg::n_rob-1]};
	endfunction

	always_comb begin
		head_at[0] = head;
		for (int w = 1; w < rob_pkg::n_way; w++) begin
			head_at[w] = step(head_at[w-1]);
		end
	end

	// gather the entries under the head tokens
	always_comb begin
		s_busy = '0;
		s_done = '0;
		s_taken = '0;
		s_kind = '0;
		s_tag = '0;
		s_told = '0;
		s_pc = '0;
		s_target = '0;
		for (int w = 0; w < rob_pkg::n_way; w++) begin
			for (int j = 0; j < rob_pkg::n_rob; j++) begin
				if (head_at[w][j]) begin
					s_busy[w] = busy[j];
					s_done[w] = done[j];
					s_taken[w] = taken_q[j];
					s_kind[w] = kind_q[j];
					s_tag[w] = tag_q[j];
					s_told[w] = told_q[j];
					s_pc[w] = pc_q[j];
					s_target[w] = target_q[j];
				end
			end
		end
	end

	// in-order retire scan
	always_comb begin
		retire_valid = '0;
		retire_tag = '0;
		retire_told = '0;
		retire_pc = '0;
		retire_halt = '0;
		retire_illegal = '0;
		branch_haz = 1'b0;
		br_target_pc = '0;
		retire_branch = 1'b0;
		retire_branch_pc = '0;
		scan_stop = 1'b0;
		for (int w = 0; w < rob_pkg::n_way; w++) begin
			if (scan_stop || !s_busy[w] || !s_done[w]) begin
				scan_stop = 1'b1;
			end else if (s_kind[w] == rob_pkg::kind_branch && s_taken[w]) begin
				// a taken branch flushes only from the head slot
				// one in a later slot waits to reach the head
				if (w == 0) begin
					branch_haz = 1'b1;
					retire_branch = 1'b1;
					br_target_pc = s_target[w];
					retire_branch_pc = s_pc[w];
				end
				scan_stop = 1'b1;
			end else if (s_kind[w] == rob_pkg::kind_branch && retire_branch) begin
				// one branch report per cycle
				scan_stop = 1'b1;
			end else begin
				retire_valid[w] = 1'b1;
				retire_tag[w] = s_tag[w];
				retire_told[w] = s_told[w];
				retire_pc[w] = s_pc[w];
				retire_halt[w] = (s_kind[w] == rob_pkg::kind_halt);
				retire_illegal[w] = (s_kind[w] == rob_pkg::kind_illegal);
				if (s_kind[w] == rob_pkg::kind_branch) begin
					retire_branch = 1'b1;
					retire_branch_pc = s_pc[w];
				end
			end
		end
	end

	always_comb begin
		retired = '0;
		n_ret = '0;
		head_next = head;
		for (int w = 0; w < rob_pkg::n_way; w++) begin
			if (retire_valid[w]) begin
				retired = retired | head_at[w];
				n_ret = n_ret + 1'b1;
				head_next = step(head_next);
			end
		end
	end

	// nothing is accepted while the ring is being flushed
	assign dis_go = branch_haz ? '0 : dis_valid;
	assign tail1 = step(tail);
	assign tail2 = step(tail1);
	assign slot0 = dis_go[0] ? tail1 : '0;
	assign slot1 = !dis_go[1] ? '0 : (dis_go[0] ? tail2 : tail1);
	assign written = slot0 | slot1;

	always_comb begin
		n_dis = '0;
		tail_next = tail;
		for (int w = 0; w < rob_pkg::n_way; w++) begin
			if (dis_go[w]) begin
				n_dis = n_dis + 1'b1;
				tail_next = step(tail_next);
			end
		end
	end

	// completions match by tag, halts mark themselves
	always_comb begin
		hit = '0;
		halt_self = '0;
		for (int j = 0; j < rob_pkg::n_rob; j++) begin
			halt_self[j] = busy[j] && (kind_q[j] == rob_pkg::kind_halt);
			for (int w = 0; w < rob_pkg::n_way; w++) begin
				if (busy[j] && !branch_haz && complete_tag[w] != rob_pkg::zero_tag &&
						complete_tag[w] == tag_q[j]) begin
					hit[j] = 1'b1;
				end
			end
		end
	end

	// a taken branch at the head returns the ring to its reset image
	always_ff @(posedge clock) begin
		if (reset || branch_haz) begin
			head <= {{(rob_pkg::n_rob-1){1'b0}}, 1'b1};
			tail <= {1'b1, {(rob_pkg::n_rob-1){1'b0}}};
			busy <= '0;
			done <= '0;
			free_cnt <= rob_pkg::rob_cnt_t'(rob_pkg::n_rob);
		end else begin
			head <= head_next;
			tail <= tail_next;
			busy <= (busy & ~retired) | written;
			done <= (done | hit | halt_self) & ~retired & ~written;
			free_cnt <= free_cnt + n_ret - n_dis;
		end
	end

	always_ff @(posedge clock) begin
		for (int j = 0; j < rob_pkg::n_rob; j++) begin
			if (slot0[j]) begin
				tag_q[j] <= dis_tag[0];
				told_q[j] <= dis_told[0];
				kind_q[j] <= dis_kind[0];
				pc_q[j] <= dis_pc[0];
			end else if (slot1[j]) begin
				tag_q[j] <= dis_tag[1];
				told_q[j] <= dis_told[1];
				kind_q[j] <= dis_kind[1];
				pc_q[j] <= dis_pc[1];
			end
			// branch outcome rides with its completion
			if (hit[j]) begin
				taken_q[j] <= take_branch;
				target_q[j] <= br_result;
			end
		end
	end

	assign flush_valid = branch_haz;

	always_comb begin
		for (int j = 0; j < rob_pkg::n_rob; j++) begin
			flush_tags[j] = busy[j] ? tag_q[j] : rob_pkg::zero_tag;
		end
	end

	// no room offered in the flush cycle
	assign rob_space = branch_haz ? '0 :
		(free_cnt >= rob_pkg::n_way) ? rob_pkg::way_cnt_t'(rob_pkg::n_way) :
		rob_pkg::way_cnt_t'(free_cnt);

endmodule

// File: hdl/rob_backend.sv
/* top of the ROB back end: free list feeding tags to the reorder buffer
   the front end dispatches here and the execute stage reports completions */
module rob_backend (
	input  logic                                        clock,
	input  logic                                        reset,

	// dispatch from the front end
	input  logic [rob_pkg::n_way-1:0]                   dis_valid,
	input  rob_pkg::inst_kind_e [rob_pkg::n_way-1:0]    dis_kind,
	input  rob_pkg::tag_t [rob_pkg::n_way-1:0]          dis_told,
	input  rob_pkg::pc_t [rob_pkg::n_way-1:0]           dis_pc,
	output rob_pkg::tag_t [rob_pkg::n_way-1:0]          dis_tag_out,

	// completions from execute
	input  rob_pkg::tag_t [rob_pkg::n_way-1:0]          complete_tag,
	input  logic                                        take_branch,
	input  rob_pkg::pc_t                                br_result,

	// retirement
	output logic [rob_pkg::n_way-1:0]                   retire_valid,
	output rob_pkg::tag_t [rob_pkg::n_way-1:0]          retire_tag,
	output rob_pkg::tag_t [rob_pkg::n_way-1:0]          retire_told,
	output rob_pkg::pc_t [rob_pkg::n_way-1:0]           retire_pc,
	output logic [rob_pkg::n_way-1:0]                   retire_halt,
	output logic [rob_pkg::n_way-1:0]                   retire_illegal,

	// branch resolution
	output logic                                        branch_haz,
	output rob_pkg::pc_t                                br_target_pc,
	output logic                                        retire_branch,
	output rob_pkg::pc_t                                retire_branch_pc,
	output logic                                        flush_valid,

	// capacity for the front end
	output rob_pkg::way_cnt_t                           rob_space,
	output rob_pkg::way_cnt_t                           tag_space
);

	rob_pkg::tag_t [rob_pkg::n_way-1:0] alloc_tag;
	rob_pkg::tag_t [rob_pkg::n_rob-1:0] flush_tags;

	// front end learns the destination tag of each way
	assign dis_tag_out = alloc_tag;

	rob u_rob (
		.clock            (clock),
		.reset            (reset),
		.dis_valid        (dis_valid),
		.dis_tag          (alloc_tag),
		.dis_told         (dis_told),
		.dis_kind         (dis_kind),
		.dis_pc           (dis_pc),
		.complete_tag     (complete_tag),
		.take_branch      (take_branch),
		.br_result        (br_result),
		.retire_valid     (retire_valid),
		.retire_tag       (retire_tag),
		.retire_told      (retire_told),
		.retire_pc        (retire_pc),
		.retire_halt      (retire_halt),
		.retire_illegal   (retire_illegal),
		.branch_haz       (branch_haz),
		.br_target_pc     (br_target_pc),
		.retire_branch    (retire_branch),
		.retire_branch_pc (retire_branch_pc),
		.flush_valid      (flush_valid),
		.flush_tags       (flush_tags),
		.rob_space        (rob_space)
	);

	free_list u_free_list (
		.clock        (clock),
		.reset        (reset),
		.dis_valid    (dis_valid),
		.retire_valid (retire_valid),
		.retire_tag   (retire_tag),
		.retire_told  (retire_told),
		.flush_valid  (flush_valid),
		.flush_tags   (flush_tags),
		.alloc_tag    (alloc_tag),
		.tag_space    (tag_space)
	);

endmodule

// File: hdl/rob_pkg.sv
/* sizes, tag and address types and the instruction kind shared by the ROB back end
   every RTL file refers to these by scoped name */
package rob_pkg;

	// dispatch, complete and retire width
	localparam int n_way = 2;

	// reorder buffer depth
	localparam int n_rob = 8;

	// physical register file size
	localparam int n_preg = 64;

	// architectural registers
	// tags 1 to n_areg-1 belong to the initial map, so they start out in use
	localparam int n_areg = 32;

	// physical register tag
	// tag 0 is the zero register and doubles as "no tag"
	typedef logic [5:0] tag_t;

	localparam tag_t zero_tag = '0;

	// instruction address, also used for branch targets
	typedef logic [31:0] pc_t;

	// free ROB entries, 0 to n_rob
	typedef logic [3:0] rob_cnt_t;

	// capacity seen by the front end, saturated at n_way
	typedef logic [1:0] way_cnt_t;

	// what a dispatched instruction is
	typedef enum logic [1:0] {
		kind_alu,
		kind_branch,
		kind_halt,
		kind_illegal
	} inst_kind_e;

endpackage

// File: rob_backend.f
+incdir+sim
hdl/rob_pkg.sv
hdl/free_list.sv
hdl/rob.sv
hdl/rob_backend.sv
sim/rob_backend_tb.sv

// File: sim/rob_model.svh
/* reference model of the ROB back end, included into the testbench module
   mirrors the entry queue and the free bitmap and predicts each cycle's outputs */
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

typedef struct {
	rob_pkg::tag_t       tag;
	rob_pkg::tag_t       told;
	rob_pkg::inst_kind_e kind;
	rob_pkg::pc_t        pc;
	logic                done;
	logic                taken;
	rob_pkg::pc_t        target;
} entry_t;

// entries in program order, oldest first
entry_t                     model_q[$];
logic [rob_pkg::n_preg-1:0] model_free;

// predicted retire and branch outputs of the current cycle
int           exp_nret;
logic         exp_flush;
logic         exp_branch;
rob_pkg::pc_t exp_branch_pc;
rob_pkg::pc_t exp_target;

function automatic void model_reset();
	model_q.delete();
	for (int i = 0; i < rob_pkg::n_preg; i++)
		model_free[i] = (i >= rob_pkg::n_areg);
endfunction

// nth lowest free tag, 0 when there is none
function automatic rob_pkg::tag_t lowest_free(input int nth);
	int seen = 0;
	for (int i = 1; i < rob_pkg::n_preg; i++) begin
		if (model_free[i]) begin
			if (seen == nth)
				return rob_pkg::tag_t'(i);
			seen++;
		end
	end
	return rob_pkg::zero_tag;
endfunction

function automatic rob_pkg::way_cnt_t space_of(input int n);
	return (n >= rob_pkg::n_way) ? rob_pkg::way_cnt_t'(rob_pkg::n_way) : rob_pkg::way_cnt_t'(n);
endfunction

// in-order scan over the oldest entries
function automatic void predict_retire();
	exp_nret = 0;
	exp_flush = 1'b0;
	exp_branch = 1'b0;
	exp_branch_pc = '0;
	exp_target = '0;
	for (int w = 0; w < rob_pkg::n_way; w++) begin
		if (w >= model_q.size() || !model_q[w].done)
			break;
		if (model_q[w].kind == rob_pkg::kind_branch) begin
			// taken branch flushes only once it is the oldest
			if (model_q[w].taken) begin
				if (w == 0) begin
					exp_flush = 1'b1;
					exp_branch = 1'b1;
					exp_branch_pc = model_q[w].pc;
					exp_target = model_q[w].target;
				end
				break;
			end
			// at most one branch reported per cycle
			if (exp_branch)
				break;
			exp_branch = 1'b1;
			exp_branch_pc = model_q[w].pc;
		end
		exp_nret++;
	end
endfunction

// apply one rising edge with the inputs seen at it, after predict_retire
function automatic void model_step(
	input logic [rob_pkg::n_way-1:0]                dv,
	input rob_pkg::inst_kind_e [rob_pkg::n_way-1:0] kinds,
	input rob_pkg::tag_t [rob_pkg::n_way-1:0]       tolds,
	input rob_pkg::pc_t [rob_pkg::n_way-1:0]        pcs,
	input rob_pkg::tag_t [rob_pkg::n_way-1:0]       ctag,
	input logic                                     take,
	input rob_pkg::pc_t                             result
);
	rob_pkg::tag_t alloc [rob_pkg::n_way];
	entry_t        e;
	if (exp_flush) begin
		foreach (model_q[i])
			model_free[model_q[i].tag] = 1'b1;
		model_q.delete();
		return;
	end
	for (int w = 0; w < rob_pkg::n_way; w++)
		alloc[w] = lowest_free(w);
	// halts mark themselves once visible, others by matching completion
	foreach (model_q[i]) begin
		if (model_q[i].kind == rob_pkg::kind_halt)
			model_q[i].done = 1'b1;
		for (int w = 0; w < rob_pkg::n_way; w++) begin
			if (ctag[w] != rob_pkg::zero_tag && ctag[w] == model_q[i].tag) begin
				model_q[i].done = 1'b1;
				model_q[i].taken = take;
				model_q[i].target = result;
			end
		end
	end
	repeat (exp_nret) begin
		e = model_q.pop_front();
		model_free[(e.told != rob_pkg::zero_tag) ? e.told : e.tag] = 1'b1;
	end
	for (int w = 0; w < rob_pkg::n_way; w++) begin
		if (dv[w] && alloc[w] != rob_pkg::zero_tag) begin
			model_free[alloc[w]] = 1'b0;
			model_q.push_back('{alloc[w], tolds[w], kinds[w], pcs[w], 1'b0, 1'b0, '0});
		end
	end
endfunction

`endif

// File: sim/rob_backend_tb.sv
/* testbench for the ROB back end, acting as front end and execute stage
   every cycle is compared against the reference model in rob_model.svh */
module rob_backend_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic                                     clock;
	logic                                     reset;
	logic [rob_pkg::n_way-1:0]                dis_valid;
	rob_pkg::inst_kind_e [rob_pkg::n_way-1:0] dis_kind;
	rob_pkg::tag_t [rob_pkg::n_way-1:0]       dis_told;
	rob_pkg::pc_t [rob_pkg::n_way-1:0]        dis_pc;
	rob_pkg::tag_t [rob_pkg::n_way-1:0]       dis_tag_out;
	rob_pkg::tag_t [rob_pkg::n_way-1:0]       complete_tag;
	logic                                     take_branch;
	rob_pkg::pc_t                             br_result;
	logic [rob_pkg::n_way-1:0]                retire_valid;
	rob_pkg::tag_t [rob_pkg::n_way-1:0]       retire_tag;
	rob_pkg::tag_t [rob_pkg::n_way-1:0]       retire_told;
	rob_pkg::pc_t [rob_pkg::n_way-1:0]        retire_pc;
	logic [rob_pkg::n_way-1:0]                retire_halt;
	logic [rob_pkg::n_way-1:0]                retire_illegal;
	logic                                     branch_haz;
	rob_pkg::pc_t                             br_target_pc;
	logic                                     retire_branch;
	rob_pkg::pc_t                             retire_branch_pc;
	logic                                     flush_valid;
	rob_pkg::way_cnt_t                        rob_space;
	rob_pkg::way_cnt_t                        tag_space;
	rob_pkg::pc_t                             next_pc;

	`include "rob_model.svh"

	rob_backend u_rob_backend (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_tag(input string name, input rob_pkg::tag_t got, input rob_pkg::tag_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_pc(input string name, input rob_pkg::pc_t got, input rob_pkg::pc_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_space(input string name, input rob_pkg::way_cnt_t got,
			input rob_pkg::way_cnt_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// compare at each rising edge, then advance the model with the same inputs
	always @(posedge clock) begin
		if (reset) begin
			model_reset();
		end else begin
			predict_retire();
			for (int w = 0; w < rob_pkg::n_way; w++)
				check_tag($sformatf("dis_tag_out[%0d]", w), dis_tag_out[w], lowest_free(w));
			check_space("tag_space", tag_space, space_of($countones(model_free)));
			check_space("rob_space", rob_space,
				exp_flush ? space_of(0) : space_of(rob_pkg::n_rob - model_q.size()));
			check_flag("branch_haz", branch_haz, exp_flush);
			check_flag("flush_valid", flush_valid, exp_flush);
			check_flag("retire_branch", retire_branch, exp_branch);
			if (exp_branch)
				check_pc("retire_branch_pc", retire_branch_pc, exp_branch_pc);
			if (exp_flush)
				check_pc("br_target_pc", br_target_pc, exp_target);
			for (int w = 0; w < rob_pkg::n_way; w++) begin
				check_flag($sformatf("retire_valid[%0d]", w), retire_valid[w], w < exp_nret);
				if (w < exp_nret) begin
					check_tag($sformatf("retire_tag[%0d]", w), retire_tag[w], model_q[w].tag);
					check_tag($sformatf("retire_told[%0d]", w), retire_told[w], model_q[w].told);
					check_pc($sformatf("retire_pc[%0d]", w), retire_pc[w], model_q[w].pc);
					check_flag($sformatf("retire_halt[%0d]", w), retire_halt[w],
						model_q[w].kind == rob_pkg::kind_halt);
					check_flag($sformatf("retire_illegal[%0d]", w), retire_illegal[w],
						model_q[w].kind == rob_pkg::kind_illegal);
				end
			end
			model_step(dis_valid, dis_kind, dis_told, dis_pc, complete_tag, take_branch, br_result);
		end
	end

	task automatic next_cycle();
		@(negedge clock);
		dis_valid = '0;
		complete_tag = '0;
		take_branch = 1'b0;
		br_result = '0;
		for (int w = 0; w < rob_pkg::n_way; w++) begin
			dis_kind[w] = rob_pkg::kind_alu;
			dis_told[w] = rob_pkg::zero_tag;
			dis_pc[w] = '0;
		end
	endtask

	task automatic put_inst(input int w, input rob_pkg::inst_kind_e kind, input rob_pkg::tag_t told);
		dis_valid[w] = 1'b1;
		dis_kind[w] = kind;
		dis_told[w] = told;
		dis_pc[w] = next_pc;
		next_pc = next_pc + 4;
	endtask

	// a held tag that no in-flight entry names, or 0 for no previous mapping
	function automatic rob_pkg::tag_t pick_told(input rob_pkg::tag_t avoid);
		int            start;
		rob_pkg::tag_t t;
		logic          clash;
		if ($urandom_range(0, 2) == 0)
			return rob_pkg::zero_tag;
		start = $urandom_range(0, rob_pkg::n_preg - 2);
		for (int k = 0; k < rob_pkg::n_preg - 1; k++) begin
			t = rob_pkg::tag_t'((start + k) % (rob_pkg::n_preg - 1) + 1);
			clash = model_free[t] || t == avoid;
			foreach (model_q[i])
				clash = clash || model_q[i].tag == t || model_q[i].told == t;
			if (!clash)
				return t;
		end
		return rob_pkg::zero_tag;
	endfunction

	// one cycle of random traffic with dispatch kept within the capacity outputs
	task automatic drive_random(input logic dispatch_on);
		int room;
		int pick;
		next_cycle();
		br_result = $urandom;
		room = (rob_space < tag_space) ? rob_space : tag_space;
		room = dispatch_on ? $urandom_range(0, room) : 0;
		for (int w = 0; w < room; w++) begin
			pick = $urandom_range(0, 15);
			put_inst(w, (pick < 11) ? rob_pkg::kind_alu : (pick < 14) ? rob_pkg::kind_branch :
				(pick == 14) ? rob_pkg::kind_halt : rob_pkg::kind_illegal,
				pick_told((w == 0) ? rob_pkg::zero_tag : dis_told[0]));
		end
		// only way 0 may complete a branch, so take_branch has one owner
		for (int w = 0; w < rob_pkg::n_way; w++) begin
			pick = $urandom_range(0, model_q.size() + 1);
			if (pick < model_q.size() && !model_q[pick].done &&
					model_q[pick].kind != rob_pkg::kind_halt &&
					(w == 0 || (model_q[pick].kind != rob_pkg::kind_branch &&
					model_q[pick].tag != complete_tag[0]))) begin
				complete_tag[w] = model_q[pick].tag;
				if (model_q[pick].kind == rob_pkg::kind_branch)
					take_branch = ($urandom_range(0, 3) == 0);
			end
		end
	endtask

	task automatic drain(input int limit);
		int n = 0;
		do begin
			drive_random(1'b0);
			n++;
			if (n > limit)
				abort_run("timeout while waiting for the ROB to drain");
		end while (model_q.size() != 0);
	endtask

	initial begin
		rob_pkg::tag_t first_tag;
		rob_pkg::tag_t br_tag;
		int            n;
		void'($urandom(32'h3ef9));
		next_pc = 32'h100;
		reset = 1'b1;
		dis_valid = '0;
		complete_tag = '0;
		take_branch = 1'b0;
		br_result = '0;
		for (int w = 0; w < rob_pkg::n_way; w++)
			dis_kind[w] = rob_pkg::kind_alu;
		dis_told = '0;
		dis_pc = '0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// capacity and first allocations out of reset
		next_cycle();
		check_space("tag_space", tag_space, 2);
		check_space("rob_space", rob_space, 2);
		check_tag("dis_tag_out[0]", dis_tag_out[0], 6'd32);
		check_tag("dis_tag_out[1]", dis_tag_out[1], 6'd33);
		put_inst(0, rob_pkg::kind_alu, 6'd1);
		put_inst(1, rob_pkg::kind_alu, rob_pkg::zero_tag);
		next_cycle();
		put_inst(0, rob_pkg::kind_illegal, 6'd2);
		put_inst(1, rob_pkg::kind_halt, rob_pkg::zero_tag);
		// complete out of order with the oldest last
		next_cycle();
		complete_tag[0] = 6'd34;
		complete_tag[1] = 6'd33;
		next_cycle();
		complete_tag[0] = 6'd32;
		drain(50);

		// taken branch behind an older entry
		next_cycle();
		first_tag = dis_tag_out[0];
		br_tag = dis_tag_out[1];
		put_inst(0, rob_pkg::kind_alu, rob_pkg::zero_tag);
		put_inst(1, rob_pkg::kind_branch, rob_pkg::zero_tag);
		next_cycle();
		put_inst(0, rob_pkg::kind_alu, rob_pkg::zero_tag);
		put_inst(1, rob_pkg::kind_alu, rob_pkg::zero_tag);
		next_cycle();
		complete_tag[0] = br_tag;
		take_branch = 1'b1;
		br_result = 32'h4000;
		next_cycle();
		complete_tag[0] = first_tag;
		n = 0;
		while (!branch_haz) begin
			n++;
			if (n > 20)
				abort_run("branch_haz never rose for the taken branch");
			next_cycle();
		end
		next_cycle();
		check_space("rob_space", rob_space, 2);

		// not-taken branch retires like any other entry
		first_tag = dis_tag_out[0];
		br_tag = dis_tag_out[1];
		put_inst(0, rob_pkg::kind_branch, rob_pkg::zero_tag);
		put_inst(1, rob_pkg::kind_alu, rob_pkg::zero_tag);
		next_cycle();
		complete_tag[0] = first_tag;
		complete_tag[1] = br_tag;
		drain(50);

		repeat (3000) drive_random(1'b1);
		drain(200);
		$display("Test completed successfully");
		$finish;
	end

endmodule
